// File: sources.f
+incdir+hdl
hdl/ahb_outstg_pkg.sv
hdl/ahb_outstg_arb.sv
hdl/ahb_outstg_addr_mux.sv
hdl/ahb_outstg_data_phase.sv
hdl/ahb_outstg.sv
sim/tb_clk_gen.sv
sim/tb_outstg_checker.sv
sim/tb_ahb_outstg.sv

// File: Makefile
# Verilator build and run for the AHB output stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_outstg
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := all tests passed

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_ahb_outstg.sv
// AHB output stage testbench
// Drives the four input ports from a stimulus table, one row per cycle,
// directed rows first and then LFSR rows
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_config.svh"

module tb_ahb_outstg
  import ahb_outstg_pkg::*;
();

  typedef struct packed {
    port_vec_t                    sel;     // HSEL per port
    port_vec_t                    held;    // held_tran per port
    htrans_t [`AHB_NUM_PORTS-1:0] trans;
    hburst_t [`AHB_NUM_PORTS-1:0] burst;
    port_vec_t                    lock;    // HMASTLOCK per port
    logic                         hready;  // Slave HREADYOUT
    port_vec_t                    write;
    haddr_t [`AHB_NUM_PORTS-1:0]  addr;
    hdata_t [`AHB_NUM_PORTS-1:0]  wdata;
  } stim_row_t;

  logic          hclk;
  logic          hresetn;
  ahb_port_arr_t ports;
  logic          hreadyout;
  ahb_ctrl_t     ctrl;
  hdata_t        hwdata;
  logic          hreadymux;
  port_vec_t     active;
  int            chk_errors;
  int            chk_checks;
  int            tb_errors  = 0;           // Timeouts
  logic          timed_out;
  logic [31:0]   lfsr_state = 32'h71b897ac;
  stim_row_t     rows[$];

  tb_clk_gen u_clk_gen (
    .o_hclk    (hclk),
    .o_hresetn (hresetn)
  );

  ahb_outstg i_dut (
    .HCLK        (hclk),
    .HRESETn     (hresetn),
    .i_ports     (ports),
    .i_hreadyout (hreadyout),
    .o_ctrl      (ctrl),
    .o_hwdata    (hwdata),
    .o_hreadymux (hreadymux),
    .o_active    (active)
  );

  tb_outstg_checker u_checker (
    .i_hclk        (hclk),
    .i_hresetn     (hresetn),
    .i_ports       (ports),
    .i_hreadyout   (hreadyout),
    .i_ctrl        (ctrl),
    .i_hwdata      (hwdata),
    .i_hreadymux   (hreadymux),
    .i_active      (active),
    .o_err_count   (chk_errors),
    .o_check_count (chk_checks)
  );

  // --------------------
  // Random source
  // --------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_step(lfsr_state);  // One step per bit
      bits       = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // --------------------
  // Stimulus table
  // --------------------
  // Trans and burst fields list port 3 first
  task automatic add_row(input port_vec_t sel, input port_vec_t held,
                         input logic [7:0] trans, input logic [11:0] burst,
                         input port_vec_t lock, input logic hready);
    stim_row_t   r;
    logic [31:0] bits;
    r.sel    = sel;
    r.held   = held;
    r.trans  = trans;
    r.burst  = burst;
    r.lock   = lock;
    r.hready = hready;
    for (int i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      r.addr[i]  = take_bits(32);
      r.wdata[i] = take_bits(32);
      bits       = take_bits(1);
      r.write[i] = bits[0];
    end
    rows.push_back(r);
  endtask

  task automatic add_random_rows(input int count);
    port_vec_t   sel;
    port_vec_t   held;
    logic [7:0]  trans;
    logic [11:0] burst;
    port_vec_t   lock;
    logic [31:0] bits;
    for (int n = 0; n < count; n++)
    begin
      bits  = take_bits(4);
      sel   = bits[3:0];
      bits  = take_bits(4);
      held  = bits[3:0] | sel;  // Mostly held when selected
      bits  = take_bits(8);
      trans = bits[7:0];
      bits  = take_bits(12);
      burst = bits[11:0];
      bits  = take_bits(8);
      lock  = bits[3:0] & bits[7:4];  // About one in four
      bits  = take_bits(2);
      add_row(sel, held, trans, burst, lock, |bits[1:0]);
    end
  endtask

  task automatic build_table();
    add_row(4'b0000, 4'b0000, 8'b00_00_00_00, 12'o0000, 4'b0000, 1'b1);  // Idle after reset
    add_row(4'b0000, 4'b0000, 8'b00_00_00_00, 12'o0000, 4'b0000, 1'b1);
    add_row(4'b1111, 4'b1111, 8'b10_10_10_10, 12'o0000, 4'b0000, 1'b1);  // All ask at once
    add_row(4'b1110, 4'b1110, 8'b10_10_10_00, 12'o0000, 4'b0000, 1'b1);
    add_row(4'b1100, 4'b1100, 8'b10_10_00_00, 12'o0000, 4'b0000, 1'b1);
    add_row(4'b0000, 4'b0000, 8'b00_00_00_00, 12'o0000, 4'b0000, 1'b1);
    add_row(4'b0100, 4'b0100, 8'b00_10_00_00, 12'o0300, 4'b0000, 1'b1);  // INCR4 on port 2
    add_row(4'b0101, 4'b0101, 8'b00_11_00_10, 12'o0300, 4'b0000, 1'b1);  // Port 0 waits
    add_row(4'b0101, 4'b0101, 8'b00_11_00_10, 12'o0300, 4'b0000, 1'b1);
    add_row(4'b0101, 4'b0101, 8'b00_01_00_10, 12'o0300, 4'b0000, 1'b1);  // BUSY beat
    add_row(4'b0101, 4'b0101, 8'b00_11_00_10, 12'o0300, 4'b0000, 1'b0);  // Slave stalls
    add_row(4'b0101, 4'b0101, 8'b00_00_00_10, 12'o0300, 4'b0000, 1'b0);  // Owner idle, grant frozen
    add_row(4'b0101, 4'b0101, 8'b00_11_00_10, 12'o0300, 4'b0000, 1'b1);
    add_row(4'b0001, 4'b0001, 8'b00_00_00_10, 12'o0000, 4'b0000, 1'b1);  // Burst over
    add_row(4'b0000, 4'b0000, 8'b00_00_00_00, 12'o0000, 4'b0000, 1'b1);
    add_row(4'b1000, 4'b1000, 8'b10_00_00_00, 12'o0000, 4'b1000, 1'b1);  // Locked port 3
    add_row(4'b1001, 4'b1001, 8'b10_00_00_10, 12'o0000, 4'b1000, 1'b1);
    add_row(4'b0001, 4'b1001, 8'b10_00_00_10, 12'o0000, 4'b1000, 1'b1);  // HSEL drops
    add_row(4'b0001, 4'b1001, 8'b10_00_00_10, 12'o0000, 4'b1000, 1'b0);  // Unselected stall
    add_row(4'b0001, 4'b0001, 8'b00_00_00_10, 12'o0000, 4'b0000, 1'b1);  // Lock released
    add_row(4'b0000, 4'b0000, 8'b00_00_00_00, 12'o0000, 4'b0000, 1'b1);
    add_random_rows(24);
  endtask

  task automatic drive_row(input stim_row_t r);
    ahb_port_arr_t nxt;
    for (int i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      nxt[i].ctrl.sel      = r.sel[i];
      nxt[i].ctrl.addr     = r.addr[i];
      nxt[i].ctrl.trans    = r.trans[i];
      nxt[i].ctrl.write    = r.write[i];
      nxt[i].ctrl.size     = 3'b010;  // Word
      nxt[i].ctrl.burst    = r.burst[i];
      nxt[i].ctrl.prot     = 4'b0011;
      nxt[i].ctrl.master   = hmaster_t'(i);
      nxt[i].ctrl.mastlock = r.lock[i];
      nxt[i].wdata         = r.wdata[i];
      nxt[i].held_tran     = r.held[i];
    end
    ports     <= nxt;
    hreadyout <= r.hready;
  endtask

  // --------------------
  // Bounded waits
  // --------------------
  task automatic wait_reset(output logic late);
    int cycles;
    cycles = 0;
    while (hresetn !== 1'b1 && cycles < 20)
    begin
      @(posedge hclk);
      cycles++;
    end
    late = (hresetn !== 1'b1);
    if (late)
    begin
      tb_errors++;
      $display("timeout while waiting for HRESETn to be released");
    end
  endtask

  task automatic wait_drain(output logic late);
    int cycles;
    cycles = 0;
    @(negedge hclk);
    while ((active !== '0 || hreadymux !== 1'b1) && cycles < 20)
    begin
      @(negedge hclk);
      cycles++;
    end
    late = (active !== '0 || hreadymux !== 1'b1);
    if (late)
    begin
      tb_errors++;
      $display("timeout while waiting for the output stage to go idle");
    end
  endtask

  initial
  begin
    stim_row_t idle_row;
    ports     = '0;
    hreadyout = 1'b1;
    build_table();
    wait_reset(timed_out);
    if (!timed_out)
    begin
      foreach (rows[r])
      begin
        @(posedge hclk);
        drive_row(rows[r]);
      end
      @(posedge hclk);
      idle_row        = '0;
      idle_row.hready = 1'b1;
      drive_row(idle_row);  // All ports idle, slave ready
      wait_drain(timed_out);
    end
    @(posedge hclk);
    $display("checks %0d, errors %0d", chk_checks, chk_errors + tb_errors);
    if (timed_out || chk_errors + tb_errors != 0)
      $display("tests failed");
    else
      $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_outstg_checker.sv
// Output stage checker
// Predicts the slave-side outputs from the arbitration, lock and
// data phase rules and compares them with the DUT every cycle
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_config.svh"

module tb_outstg_checker
  import ahb_outstg_pkg::*;
(
  input  wire logic          i_hclk,
  input  wire logic          i_hresetn,
  input  wire ahb_port_arr_t i_ports,
  input  wire logic          i_hreadyout,
  input  wire ahb_ctrl_t     i_ctrl,
  input  wire hdata_t        i_hwdata,
  input  wire logic          i_hreadymux,
  input  wire port_vec_t     i_active,
  output int                 o_err_count,    // Mismatches seen
  output int                 o_check_count   // Cycles compared
);

  // --------------------
  // Reference model
  // --------------------
  port_idx_t m_grant     = '0;    // Address phase owner
  logic      m_no_port   = 1'b1;
  logic      m_lock      = 1'b0;  // Lock entered through this slave
  port_idx_t m_data_port = '0;    // Data phase owner
  logic      m_slave_sel = 1'b0;  // Slave selected in data phase
  logic      m_valid     = 1'b0;  // Model has seen reset
  port_idx_t n_grant     = '0;    // Next state, set on falling edge
  logic      n_no_port   = 1'b1;
  logic      n_lock      = 1'b0;
  port_idx_t n_data_port = '0;
  logic      n_slave_sel = 1'b0;
  logic      n_valid     = 1'b0;
  int        errors      = 0;
  int        checks      = 0;

  task automatic compare_value(input string name, input logic [127:0] exp_val,
                               input logic [127:0] got_val);
    if (exp_val !== got_val)
    begin
      errors++;
      $display("ERR %0t %s exp=%0h got=%0h", $time, name, exp_val, got_val);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge i_hclk)
  begin : predict
    ahb_ctrl_t e_ctrl;
    port_vec_t e_active;
    logic      e_ready;
    port_vec_t req;
    logic      keep;
    e_ctrl   = m_no_port ? '0 : i_ports[m_grant].ctrl;
    e_active = m_no_port ? '0 : port_vec_t'(1) << m_grant;
    e_ready  = m_slave_sel ? i_hreadyout : 1'b1;  // Unselected slave never stalls
    if (m_valid)
    begin
      checks++;
      compare_value("o_active", 128'(e_active), 128'(i_active));
      compare_value("o_ctrl", 128'(e_ctrl), 128'(i_ctrl));
      compare_value("o_hwdata", 128'(i_ports[m_data_port].wdata), 128'(i_hwdata));
      compare_value("o_hreadymux", 128'(e_ready), 128'(i_hreadymux));
    end
    n_grant     = m_grant;
    n_no_port   = m_no_port;
    n_lock      = m_lock;
    n_data_port = m_data_port;
    n_slave_sel = m_slave_sel;
    n_valid     = m_valid;
    if (!i_hresetn)
    begin
      n_grant     = '0;
      n_no_port   = 1'b1;
      n_lock      = 1'b0;
      n_data_port = '0;
      n_slave_sel = 1'b0;
      n_valid     = 1'b1;
    end
    else if (e_ready)  // State moves only on accepted phases
    begin
      foreach (req[i])
        req[i] = i_ports[i].held_tran & i_ports[i].ctrl.sel;
      keep = e_ctrl.mastlock & (m_lock | e_ctrl.sel);  // Locked owner
      if (!m_no_port && req[m_grant] && e_ctrl.trans != HTRANS_IDLE &&
          e_ctrl.burst != HBURST_SINGLE)
        keep = 1'b1;  // Burst still running
      if (!keep)
      begin
        n_no_port = (req == '0);
        for (int i = `AHB_NUM_PORTS - 1; i >= 0; i--)
          if (req[i])
            n_grant = port_idx_t'(i);  // Lowest port wins
      end
      if (e_ctrl.sel && e_ctrl.mastlock &&
          (e_ctrl.trans == HTRANS_NONSEQ || e_ctrl.trans == HTRANS_SEQ))
        n_lock = 1'b1;
      else if (!e_ctrl.mastlock)
        n_lock = 1'b0;
      n_data_port = m_grant;
      n_slave_sel = e_ctrl.sel;
    end
  end

  always @(posedge i_hclk)
  begin
    m_grant     <= n_grant;
    m_no_port   <= n_no_port;
    m_lock      <= n_lock;
    m_data_port <= n_data_port;
    m_slave_sel <= n_slave_sel;
    m_valid     <= n_valid;
  end

  assign o_err_count   = errors;
  assign o_check_count = checks;

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// Testbench clock and reset
// 20 ns HCLK, HRESETn held low for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_hclk,    // HCLK
  output logic o_hresetn  // Sync reset, active low
);

  initial
  begin
    o_hclk    = 1'b0;
    o_hresetn = 1'b0;
    repeat (5) @(posedge o_hclk);
    o_hresetn <= 1'b1;  // Released on an edge like the other inputs
  end

  always #10 o_hclk = ~o_hclk;  // 20 ns period

endmodule

`default_nettype wire

// File: hdl/ahb_outstg.sv
// AHB bus matrix output stage
// Four input ports share one slave through a fixed priority arbiter
`timescale 1ns/1ps
`default_nettype none

module ahb_outstg
  import ahb_outstg_pkg::*;
(
  input  wire logic          HCLK,         // AHB clock
  input  wire logic          HRESETn,      // Sync reset, active low
  input  wire ahb_port_arr_t i_ports,      // Input stage requests
  input  wire logic          i_hreadyout,  // Slave HREADYOUT
  output ahb_ctrl_t          o_ctrl,       // Slave address/control
  output hdata_t             o_hwdata,     // Slave write data
  output logic               o_hreadymux,  // HREADY to the slave
  output port_vec_t          o_active      // Per-port active flags
);

  port_vec_t req;           // Per-port request
  port_idx_t addr_in_port;  // Granted port
  logic      no_port;       // No grant
  ahb_ctrl_t ctrl;          // Routed control
  logic      hlock_arb;     // Lock for arbitration
  logic      hreadymux;     // Internal HREADYMUX

  // Request is a held transfer addressed to this slave
  always_comb
  begin
    foreach (req[i])
      req[i] = i_ports[i].held_tran & i_ports[i].ctrl.sel;
  end

  ahb_outstg_arb u_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req          (req),
    .i_hreadym      (hreadymux),
    .i_ctrl         (ctrl),
    .i_hlock_arb    (hlock_arb),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  ahb_outstg_addr_mux u_addr_mux (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_ports        (i_ports),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .i_hreadym      (hreadymux),
    .o_ctrl         (ctrl),
    .o_active       (o_active),
    .o_hlock_arb    (hlock_arb)
  );

  ahb_outstg_data_phase u_data_phase (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_ports        (i_ports),
    .i_addr_in_port (addr_in_port),
    .i_hsel         (ctrl.sel),
    .i_hreadyout    (i_hreadyout),
    .o_hwdata       (o_hwdata),
    .o_hreadymux    (hreadymux)
  );

  assign o_ctrl      = ctrl;
  assign o_hreadymux = hreadymux;

endmodule

`default_nettype wire

// File: hdl/ahb_outstg_data_phase.sv
// AHB output stage data phase
// Tracks which port owns the data phase and whether the slave
// was selected, muxes write data and forms HREADYMUX
`timescale 1ns/1ps
`default_nettype none

module ahb_outstg_data_phase
  import ahb_outstg_pkg::*;
(
  input  wire logic          HCLK,            // AHB clock
  input  wire logic          HRESETn,         // Sync reset, active low
  input  wire ahb_port_arr_t i_ports,         // All input stage requests
  input  wire port_idx_t     i_addr_in_port,  // Address phase grant
  input  wire logic          i_hsel,          // Routed HSEL
  input  wire logic          i_hreadyout,     // Slave HREADYOUT
  output hdata_t             o_hwdata,        // Slave write data
  output logic               o_hreadymux      // Transfer done
);

  port_idx_t data_in_port;  // Data phase owner
  logic      slave_sel;     // Slave selected in data phase

  // --------------------
  // Data phase registers
  // --------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;
    end
    else if (o_hreadymux)  // Advance on accepted address phase
    begin
      data_in_port <= i_addr_in_port;
      slave_sel    <= i_hsel;
    end
  end

  // Write data from the data phase owner
  assign o_hwdata = i_ports[data_in_port].wdata;

  // --------------------
  // HREADYMUX
  // --------------------
  // Slave's ready when it owns the data phase, else always ready
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

`default_nettype wire

// File: hdl/ahb_outstg_addr_mux.sv
// AHB output stage address mux
// Routes the granted port's address and control to the slave,
// decodes per-port active flags and tracks locked sequences
`timescale 1ns/1ps
`default_nettype none

module ahb_outstg_addr_mux
  import ahb_outstg_pkg::*;
(
  input  wire logic          HCLK,            // AHB clock
  input  wire logic          HRESETn,         // Sync reset, active low
  input  wire ahb_port_arr_t i_ports,         // All input stage requests
  input  wire port_idx_t     i_addr_in_port,  // Granted port
  input  wire logic          i_no_port,       // Nothing granted
  input  wire logic          i_hreadym,       // HREADYMUX
  output ahb_ctrl_t          o_ctrl,          // Slave address/control
  output port_vec_t          o_active,        // One-hot grant per port
  output logic               o_hlock_arb      // Lock seen by the arbiter
);

  ahb_ctrl_t ctrl;            // Routed control
  logic      hsel_lock;       // Lock held while HSEL drops
  logic      next_hsel_lock;  // D input of hsel_lock
  logic      lock_start;      // Selected locked NONSEQ/SEQ

  // --------------------
  // Address/control mux
  // --------------------
  assign ctrl = i_no_port ? '0 : i_ports[i_addr_in_port].ctrl;  // All zero when idle

  // Active decode
  assign o_active = i_no_port ? '0 : (port_vec_t'(1'b1) << i_addr_in_port);

  // --------------------
  // Lock tracking
  // --------------------
  // A master may address another slave in the middle of a locked
  // sequence; HSEL then drops but the output must stay locked
  assign lock_start = ctrl.sel && ctrl.mastlock &&
                      ((ctrl.trans == HTRANS_NONSEQ) || (ctrl.trans == HTRANS_SEQ));

  always_comb
  begin
    if (lock_start)
      next_hsel_lock = 1'b1;       // Sequence entered via this slave
    else if (!ctrl.mastlock)
      next_hsel_lock = 1'b0;       // Lock released
    else
      next_hsel_lock = hsel_lock;  // Locked, HSEL elsewhere
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (i_hreadym)
      hsel_lock <= next_hsel_lock;
  end

  // Lock masked by HSEL unless the sequence already started here
  assign o_hlock_arb = ctrl.mastlock & (hsel_lock | ctrl.sel);

  assign o_ctrl = ctrl;

endmodule

`default_nettype wire

// File: hdl/ahb_outstg_arb.sv
// AHB output stage arbiter
// Registered fixed priority, lowest port wins
// Holds the grant through locked sequences and non-single bursts
`timescale 1ns/1ps
`default_nettype none

`include "ahb_outstg_config.svh"

module ahb_outstg_arb
  import ahb_outstg_pkg::*;
(
  input  wire logic      HCLK,            // AHB clock
  input  wire logic      HRESETn,         // Sync reset, active low
  input  wire port_vec_t i_req,           // held_tran & sel per port
  input  wire logic      i_hreadym,       // Address phase completes
  input  wire ahb_ctrl_t i_ctrl,          // Routed control of current owner
  input  wire logic      i_hlock_arb,     // Lock qualified by HSEL
  output port_idx_t      o_addr_in_port,  // Granted port
  output logic           o_no_port        // No port granted
);

  port_idx_t addr_in_port;  // Grant register
  logic      no_port;       // Grant empty flag
  port_idx_t next_port;     // Priority encoder result
  logic      burst_hold;    // Owner mid burst
  logic      hold_grant;    // Keep current owner

  // --------------------
  // Hold conditions
  // --------------------
  // Active transfer of an incrementing or wrapping burst
  assign burst_hold = i_req[addr_in_port] &&
                      (i_ctrl.trans != HTRANS_IDLE) &&
                      (i_ctrl.burst != HBURST_SINGLE);

  assign hold_grant = i_hlock_arb | burst_hold;  // Zero ctrl when no_port

  // --------------------
  // Priority encoder
  // --------------------
  always_comb
  begin
    next_port = addr_in_port;  // Index kept when nobody asks
    for (int i = `AHB_NUM_PORTS - 1; i >= 0; i--)
    begin
      if (i_req[i])
      begin
        next_port = port_idx_t'(i);  // Lower index overrides
      end
    end
  end

  // --------------------
  // Grant register
  // --------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      addr_in_port <= '0;
      no_port      <= 1'b1;  // Nothing granted out of reset
    end
    else if (i_hreadym)  // Frozen while slave stalls
    begin
      if (hold_grant)
      begin
        addr_in_port <= addr_in_port;  // Owner keeps the slave
      end
      else if (|i_req)
      begin
        addr_in_port <= next_port;
        no_port      <= 1'b0;
      end
      else
      begin
        no_port <= 1'b1;  // Idle, last index retained
      end
    end
  end

  assign o_addr_in_port = addr_in_port;
  assign o_no_port      = no_port;

endmodule

`default_nettype wire

// File: hdl/ahb_outstg_pkg.sv
// AHB output stage types
// Vector typedefs, transfer codes and the per-port request structs
`default_nettype none

package ahb_outstg_pkg;

  `include "ahb_outstg_config.svh"

  // --------------------
  // Vector types
  // --------------------
  typedef logic [`AHB_ADDR_W-1:0]     haddr_t;     // Address
  typedef logic [`AHB_DATA_W-1:0]     hdata_t;     // Write data
  typedef logic [1:0]                 htrans_t;    // Transfer type
  typedef logic [2:0]                 hsize_t;     // Transfer size
  typedef logic [2:0]                 hburst_t;    // Burst type
  typedef logic [3:0]                 hprot_t;     // Protection
  typedef logic [3:0]                 hmaster_t;   // Master id
  typedef logic [`AHB_PORT_IDX_W-1:0] port_idx_t;  // Port number
  typedef logic [`AHB_NUM_PORTS-1:0]  port_vec_t;  // One bit per port

  // HTRANS encodings
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  localparam hburst_t HBURST_SINGLE = 3'b000;  // Single transfer burst

  // --------------------
  // Request structs
  // --------------------
  typedef struct packed {
    logic     sel;       // HSEL for this slave
    haddr_t   addr;
    htrans_t  trans;
    logic     write;     // High for write
    hsize_t   size;
    hburst_t  burst;
    hprot_t   prot;
    hmaster_t master;
    logic     mastlock;  // Locked sequence
  } ahb_ctrl_t;

  typedef struct packed {
    ahb_ctrl_t ctrl;       // Address phase signals
    hdata_t    wdata;      // Data phase write data
    logic      held_tran;  // Input stage holds a transfer
  } ahb_port_t;

  typedef ahb_port_t [`AHB_NUM_PORTS-1:0] ahb_port_arr_t;  // All input ports

endpackage

`default_nettype wire

// File: hdl/ahb_outstg_config.svh
// AHB output stage configuration
// Port count and bus widths shared by the package and the RTL

`ifndef AHB_OUTSTG_CONFIG_SVH
`define AHB_OUTSTG_CONFIG_SVH

// --------------------
// Port count
// --------------------
`define AHB_NUM_PORTS   4   // Input ports competing for the slave
`define AHB_PORT_IDX_W  2   // Enough bits to index every port

// --------------------
// Bus widths
// --------------------
`define AHB_ADDR_W      32  // HADDR width
`define AHB_DATA_W      32  // HWDATA width

`endif
